// File: design/gfx_defs.svh
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// parallel fmul lanes, one operand pair each.
`define GFX_FMUL_LANES 2

// single precision field layout.
`define GFX_FLOAT_EXP_BITS  8
`define GFX_FLOAT_MANT_BITS 23

// exponent bias of the binary32 format.
`define GFX_FLOAT_EXP_BIAS 127

// register stages inside gfx_fmul_lane.
`define GFX_FMUL_LANE_STAGES 2

`endif

// File: design/gfx.sv
`include "gfx_defs.svh"

package gfx;

	// raw field types.
	typedef logic [`GFX_FLOAT_EXP_BITS-1:0]  float_exp;
	typedef logic [`GFX_FLOAT_MANT_BITS-1:0] float_mant;
	typedef logic [`GFX_FLOAT_MANT_BITS:0]   float_mant_full; // hidden one on top.

	// one ieee-754 binary32 word, msb first.
	typedef struct packed {
		logic      sign;
		float_exp  exp;
		float_mant mant;
	} float;

	// operand after input classification.
	typedef struct packed {
		float val;
		logic exp_min; // exponent field zero, operand counts as zero.
		logic slow;    // inf or nan operand.
	} float_special;

	// normalized product, not yet rounded.
	typedef struct packed {
		float normal;
		logic guard;  // first dropped bit.
		logic round;  // second dropped bit.
		logic sticky; // or of everything below.
		logic zero;
		logic slow;
	} float_round;

	localparam int FLOAT_BITS = $bits(float);

	localparam float_exp FLOAT_EXP_BIAS = float_exp'(`GFX_FLOAT_EXP_BIAS);
	localparam float_exp FLOAT_EXP_MAX  = '1; // inf/nan encoding.

	// 1.m from the stored mantissa.
	function automatic float_mant_full full_mant(input float_mant m);
		return {1'b1, m};
	endfunction

	// strip the hidden one again.
	// caller guarantees the msb is set, it is simply dropped.
	function automatic float_mant implicit_mant(input float_mant_full m);
		return m[$bits(float_mant)-1:0];
	endfunction

endpackage

// File: design/gfx_fp_classify.sv
`timescale 1ns/1ns

`include "gfx_defs.svh"

module gfx_fp_classify (
	input  logic clk,
	input  logic rst,

	input  logic in_valid,
	input  logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] a,
	input  logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] b,

	output gfx::float_special [`GFX_FMUL_LANES-1:0] ops_a,
	output gfx::float_special [`GFX_FMUL_LANES-1:0] ops_b,
	output logic [`GFX_FMUL_LANES-1:0] slow_in, // per lane, either operand special.
	output logic valid_c
);

	logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] raw_a, raw_b; // captured operands.

	// split one raw word and tag it.
	function automatic gfx::float_special unpack(input logic [gfx::FLOAT_BITS-1:0] w);
		gfx::float_special s;
		s.val = gfx::float'(w);
		s.exp_min = s.val.exp == '0;                // zero or denormal, flushed.
		s.slow = s.val.exp == gfx::FLOAT_EXP_MAX;  // inf or nan.
		if (s.exp_min)
			s.val.mant = '0; // denormal fraction is discarded.
		return s;
	endfunction

	always_ff @(posedge clk) begin
		raw_a <= a; // payload, no reset.
		raw_b <= b;
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_c <= 1'b0;
		else
			valid_c <= in_valid;
	end

	always_comb begin
		for (int i = 0; i < `GFX_FMUL_LANES; i++) begin
			ops_a[i] = unpack(raw_a[i]);
			ops_b[i] = unpack(raw_b[i]);
			slow_in[i] = ops_a[i].slow | ops_b[i].slow; // lane goes slow on either side.
		end
	end

endmodule

// File: design/gfx_fmul_lane.sv
`timescale 1ns/1ns

module gfx_fmul_lane (
	input  logic              clk,

	input  gfx::float_special a,
	input  gfx::float_special b,
	input  logic              slow_in,

	output gfx::float_round   q
);

	// q = a * b with a = (-1)^s 1.m 2^f and b = (-1)^t 1.n 2^g.
	// both significands lie in [1, 2), so the product lies in [1, 4).
	// a product of 2 or more needs one right shift and exponent + 1.

	logic sign, zero, slow_0;        // stage 0 flags.
	logic overflow_0, overflow_1;    // exponent carry/borrow per stage.
	logic guard, round;              // bits just below the 24-bit top.
	logic lo_msb, lo_reduce;

	gfx::float_exp exp;              // biased exponent sum.
	gfx::float_mant_full hi;         // top of the 48-bit product.
	logic [$bits(gfx::float_mant_full)-3:0] lo;
	gfx::float_round st1;            // stage 1 result.

	assign lo_msb = lo[$bits(lo)-1];
	assign lo_reduce = |lo[$bits(lo)-2:0];

	always_comb begin
		q = st1;
		q.slow = st1.slow | (overflow_1 & ~st1.zero); // normalize carry out of range.
	end

	always_ff @(posedge clk) begin
		// stage 0, sign, exponent sum and mantissa product.
		sign <= a.val.sign ^ b.val.sign;
		zero <= a.exp_min | b.exp_min;
		slow_0 <= slow_in;

		// bit 8 catches both overflow and a borrow below zero.
		{overflow_0, exp} <= {1'b0, a.val.exp} + {1'b0, b.val.exp}
			- {1'b0, gfx::FLOAT_EXP_BIAS};
		{hi, guard, round, lo} <= gfx::full_mant(a.val.mant) * gfx::full_mant(b.val.mant);

		// stage 1, normalize by at most one bit.
		st1.slow <= slow_0 | (overflow_0 & ~zero); // a zero result has no exponent.
		st1.zero <= zero;
		st1.normal.sign <= sign;
		overflow_1 <= 1'b0;

		if (hi[$bits(hi)-1]) begin
			// product in [2, 4), shift right once.
			st1.guard <= guard;
			st1.round <= round;
			st1.sticky <= lo_msb | lo_reduce;
			st1.normal.mant <= gfx::implicit_mant(hi);
			{overflow_1, st1.normal.exp} <= {1'b0, exp} + 9'd1;
		end else begin
			// product in [1, 2), next bit down is the hidden one.
			st1.guard <= round;
			st1.round <= lo_msb;
			st1.sticky <= lo_reduce;
			st1.normal.exp <= exp;
			st1.normal.mant <= gfx::implicit_mant({hi[$bits(hi)-2:0], guard});
		end
	end

endmodule

// File: design/gfx_fp_round.sv
`timescale 1ns/1ns

`include "gfx_defs.svh"

module gfx_fp_round (
	input  logic clk,
	input  logic rst,

	input  logic valid_c,
	input  gfx::float_round [`GFX_FMUL_LANES-1:0] r,

	output logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] q,
	output logic [`GFX_FMUL_LANES-1:0] slow,
	output logic out_valid
);

	logic [`GFX_FMUL_LANE_STAGES-1:0] valid_sr; // valid beside the lane stages.

	logic [`GFX_FMUL_LANES-1:0] inc;        // round up by one ulp.
	logic [`GFX_FMUL_LANES-1:0] mant_carry; // 1.111.. rolled over to 10.000..
	logic [`GFX_FMUL_LANES-1:0] exp_carry;
	logic [`GFX_FMUL_LANES-1:0] big, tiny;  // result out of the normal range.

	gfx::float_mant [`GFX_FMUL_LANES-1:0] mant_rnd;
	gfx::float_exp  [`GFX_FMUL_LANES-1:0] exp_rnd;

	always_comb begin
		for (int i = 0; i < `GFX_FMUL_LANES; i++) begin
			// nearest even, ties go to an even lsb.
			inc[i] = r[i].guard & (r[i].round | r[i].sticky | r[i].normal.mant[0]);

			{mant_carry[i], mant_rnd[i]} = {1'b0, r[i].normal.mant} + inc[i];
			// on carry the mantissa is already zero, only the exponent moves.
			{exp_carry[i], exp_rnd[i]} = {1'b0, r[i].normal.exp} + mant_carry[i];

			big[i] = exp_carry[i] | (exp_rnd[i] == gfx::FLOAT_EXP_MAX); // overflow.
			tiny[i] = r[i].normal.exp == '0; // denormal range result.
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `GFX_FMUL_LANES; i++) begin
			if (r[i].zero) begin
				// signed zero, special operand still reported.
				q[i] <= {r[i].normal.sign, {(gfx::FLOAT_BITS-1){1'b0}}};
				slow[i] <= r[i].slow;
			end else begin
				q[i] <= {r[i].normal.sign, exp_rnd[i], mant_rnd[i]};
				slow[i] <= r[i].slow | big[i] | tiny[i];
			end
		end
	end

	// valid pipeline, matched to classify + lane + this stage.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_sr <= '0;
			out_valid <= 1'b0;
		end else begin
			valid_sr <= {valid_sr[`GFX_FMUL_LANE_STAGES-2:0], valid_c}; // shift in at the bottom.
			out_valid <= valid_sr[`GFX_FMUL_LANE_STAGES-1];
		end
	end

endmodule

// File: design/gfx_fmul.sv
`timescale 1ns/1ns

`include "gfx_defs.svh"

module gfx_fmul (
	input  logic clk,
	input  logic rst,

	input  logic in_valid, // one set of operands for every lane.
	input  logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] a,
	input  logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] b,

	output logic out_valid,
	output logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] q,
	output logic [`GFX_FMUL_LANES-1:0] slow // lane result needs the slow path.
);

	gfx::float_special [`GFX_FMUL_LANES-1:0] ops_a, ops_b;
	gfx::float_round   [`GFX_FMUL_LANES-1:0] prod; // per lane, unrounded.

	logic [`GFX_FMUL_LANES-1:0] slow_in;
	logic valid_c;

	gfx_fp_classify i_classify (
		.clk, .rst, .in_valid, .a, .b,
		.ops_a, .ops_b, .slow_in, .valid_c
	);

	for (genvar i = 0; i < `GFX_FMUL_LANES; i++) begin : g_lane
		gfx_fmul_lane i_lane (
			.clk,
			.a(ops_a[i]),
			.b(ops_b[i]),
			.slow_in(slow_in[i]),
			.q(prod[i])
		);
	end

	// rounding and packing for all lanes.
	gfx_fp_round i_round (
		.clk, .rst, .valid_c,
		.r(prod),
		.q, .slow, .out_valid
	);

endmodule

// File: tests/gfx_fmul_assertions.sv
`timescale 1ns/1ns

`include "gfx_defs.svh"

module gfx_fmul_assertions (
	input logic clk,
	input logic rst,
	input logic in_valid,
	input logic out_valid,
	input logic [`GFX_FMUL_LANES-1:0][gfx::FLOAT_BITS-1:0] q,
	input logic [`GFX_FMUL_LANES-1:0] slow
);

	// valid pipeline is cleared by reset.
	assert property (@(posedge clk) rst |=> !out_valid)
		else $error("out_valid high in the cycle after reset");

	// fixed latency, every strobe gives one result and nothing else does.
	assert property (@(posedge clk) disable iff (rst) in_valid |-> ##4 out_valid)
		else $error("no out_valid 4 cycles after in_valid");
	assert property (@(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 4))
		else $error("out_valid without an in_valid 4 cycles earlier");

	assert property (@(posedge clk) disable iff (rst) out_valid |-> !$isunknown({q, slow}))
		else $error("q or slow unknown while out_valid is high");

endmodule

bind gfx_fmul gfx_fmul_assertions i_assertions (.*);

// File: tests/gfx_fmul_tb.sv
`timescale 1ns/1ns

`include "gfx_defs.svh"

module gfx_fmul_tb;

	localparam int LANES = `GFX_FMUL_LANES;
	localparam int STIM_CYCLES = 600;  // driven cycles after reset.
	localparam int DRAIN_TIMEOUT = 20; // cycles allowed to empty the pipeline.

	logic clk;
	logic rst;
	logic in_valid;
	logic [LANES-1:0][31:0] a, b;
	logic out_valid;
	logic [LANES-1:0][31:0] q;
	logic [LANES-1:0] slow;

	logic [31:0] rng_state = 32'h6446;

	// expected results, one entry per accepted operand set.
	logic [LANES-1:0][31:0] exp_q[$];
	logic [LANES-1:0] exp_slow[$];

	int q_errs = 0;
	int slow_errs = 0;
	int proto_errs = 0;
	int n_sent = 0;
	int n_recv = 0;
	int n_slow = 0; // lanes that went to the slow path.

	gfx_fmul i_gfx_fmul (
		.clk, .rst, .in_valid, .a, .b,
		.out_valid, .q, .slow
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// lcg, upper bits folded down since the low bits repeat quickly.
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state ^ (rng_state >> 15);
	endfunction

	// reference product on the raw fields, returns {slow, word}.
	function automatic logic [32:0] mul_model(input logic [31:0] x, input logic [31:0] y);
		logic sign, special, g, r, s, up, slow_r;
		int e0, e1, e2;
		logic [47:0] p;
		logic [22:0] m;
		logic [23:0] mr;
		sign = x[31] ^ y[31];
		special = (x[30:23] == 8'hff) || (y[30:23] == 8'hff);
		if (x[30:23] == 8'h00 || y[30:23] == 8'h00)
			return {special, sign, 31'b0}; // zero or flushed denormal.
		p = {24'b0, 1'b1, x[22:0]} * {24'b0, 1'b1, y[22:0]};
		e0 = int'(x[30:23]) + int'(y[30:23]) - 127;
		if (p[47]) begin
			e1 = e0 + 1; // product in [2, 4).
			m = p[46:24];
			g = p[23];
			r = p[22];
			s = |p[21:0];
		end else begin
			e1 = e0;
			m = p[45:23];
			g = p[22];
			r = p[21];
			s = |p[20:0];
		end
		up = g & (r | s | m[0]); // nearest, ties to even.
		mr = {1'b0, m} + 24'(up);
		e2 = e1 + int'(mr[23]); // rounding carry bumps the exponent.
		// exact only when the final exponent is a normal one.
		slow_r = special || e0 < 0 || e1 <= 0 || e2 >= 255;
		return {slow_r, sign, 8'(e2), mr[22:0]};
	endfunction

	// one operand pair, mostly mid-range, sometimes special or near the edges.
	task automatic make_pair(output logic [31:0] x, output logic [31:0] y);
		logic [31:0] r0, r1, r2;
		logic [22:0] mx, my;
		int ex, ey, e0;
		r0 = next_rand();
		r1 = next_rand();
		r2 = next_rand();
		mx = r1[22:0];
		my = r2[22:0];
		ex = 100 + int'(r1[31:24]) % 56;
		ey = 100 + int'(r2[31:24]) % 56;
		case (r0[4:0])
			5'd0: begin
				ex = 0; // true zero.
				mx = '0;
			end
			5'd1: ex = 0; // denormal, flushed.
			5'd2: begin
				ey = 255; // infinity.
				my = '0;
			end
			5'd3: begin
				ey = 255;
				my[0] = 1'b1; // nan.
			end
			5'd4: begin
				ex = 130 + int'(r1[31:24]) % 121;
				e0 = 253 + int'(r0[6:5]); // around the top exponent.
				ey = e0 + 127 - ex;
			end
			5'd5: begin
				ex = 1 + int'(r1[31:24]) % 120;
				e0 = -2 + int'(r0[6:5]); // around the bottom exponent.
				ey = e0 + 127 - ex;
			end
			5'd6, 5'd7, 5'd8, 5'd9: begin
				mx &= 23'h7ff800; // short significands, ties are common.
				my &= 23'h7ff800;
			end
			5'd10: begin
				// (2 - 2k ulp) * (1 + k ulp) lands just below 2.
				my = 23'(1 + r2[1:0]);
				mx = 23'h7fffff - 23'(2 * my - 1); // rounds up into the exponent.
			end
			default: ;
		endcase
		x = {r0[8], 8'(ex), mx};
		y = {r0[9], 8'(ey), my};
	endtask

	task automatic check_result(input logic [LANES-1:0][31:0] want_q,
			input logic [LANES-1:0] want_slow);
		for (int i = 0; i < LANES; i++) begin
			assert (slow[i] === want_slow[i])
			else begin
				slow_errs++;
				$display("ERR %0t slow[%0d] expected %b got %b", $time, i, want_slow[i], slow[i]);
			end
			if (want_slow[i])
				n_slow++; // q is undefined here.
			else begin
				assert (q[i] === want_q[i])
				else begin
					q_errs++;
					$display("ERR %0t q[%0d] expected %h got %h", $time, i, want_q[i], q[i]);
				end
			end
		end
	endtask

	// scoreboard, outputs are settled at the falling edge.
	always @(negedge clk) begin
		if (rst === 1'b0 && out_valid === 1'b1) begin
			assert (exp_q.size() > 0)
			else begin
				proto_errs++;
				$display("out_valid rose at %0t with no operand set outstanding", $time);
			end
			if (exp_q.size() > 0) begin
				check_result(exp_q.pop_front(), exp_slow.pop_front());
				n_recv++;
			end
		end
	end

	initial begin
		logic [LANES-1:0][31:0] na, nb, eq;
		logic [LANES-1:0] es;
		logic [32:0] res;
		logic [31:0] r;
		logic v;
		int waited;
		rst = 1'b1;
		in_valid = 1'b0;
		a = '0;
		b = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (out_valid === 1'b0)
		else begin
			proto_errs++;
			$display("ERR %0t out_valid expected 0 got %b", $time, out_valid);
		end

		for (int c = 0; c < STIM_CYCLES; c++) begin
			@(posedge clk);
			r = next_rand();
			v = (c >= 200 && c < 300) ? 1'b1 : (r[31:28] < 4'd9); // burst keeps 4 in flight.
			for (int i = 0; i < LANES; i++) begin
				make_pair(na[i], nb[i]);
				res = mul_model(na[i], nb[i]);
				es[i] = res[32];
				eq[i] = res[31:0];
			end
			in_valid <= v;
			a <= na;
			b <= nb;
			if (v) begin
				exp_q.push_back(eq);
				exp_slow.push_back(es);
				n_sent++;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;

		waited = 0;
		while (exp_q.size() > 0 && waited < DRAIN_TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		assert (exp_q.size() == 0)
		else begin
			proto_errs++;
			$display("timeout, %0d results never left the pipeline", exp_q.size());
		end
		repeat (8) @(posedge clk); // idle tail, a stray out_valid shows up here.
		assert (n_recv == n_sent)
		else begin
			proto_errs++;
			$display("ERR %0t result count expected %0d got %0d", $time, n_sent, n_recv);
		end

		$display("errors q %0d slow %0d protocol %0d, %0d sets checked, %0d slow lanes",
			q_errs, slow_errs, proto_errs, n_recv, n_slow);
		if (q_errs + slow_errs + proto_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: sim.f
+incdir+design
design/gfx.sv
design/gfx_fp_classify.sv
design/gfx_fmul_lane.sv
design/gfx_fp_round.sv
design/gfx_fmul.sv
tests/gfx_fmul_assertions.sv
tests/gfx_fmul_tb.sv

// File: Bender.yml
package:
  name: gfx_fmul

export_include_dirs:
  - design

sources:
  - files:
      - design/gfx.sv
      - design/gfx_fp_classify.sv
      - design/gfx_fmul_lane.sv
      - design/gfx_fp_round.sv
      - design/gfx_fmul.sv
  - target: test
    files:
      - tests/gfx_fmul_assertions.sv
      - tests/gfx_fmul_tb.sv
